// File: lc3b_cfg.svh
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

// number of 16-bit words in the unified memory.
`define LC3B_MEM_WORDS 512

// cycles from a grant to the response strobe.
`define LC3B_MEM_LAT 3

`endif

// File: lc3b_types.sv
`default_nettype none

package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [8:0]  lc3b_addr;
    typedef logic [2:0]  lc3b_nzp;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldw  = 4'b0110,
        op_stw  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic {
        arb_idle,
        arb_busy
    } lc3b_arb_state;

    // a br with nzp 000 is never taken, so it is not a transfer.
    function automatic logic is_control(lc3b_opcode op, lc3b_nzp nzp);
        logic ctrl;
        case (op)
            op_br:                   ctrl = (nzp != 3'b000);
            op_jmp, op_jsr, op_trap: ctrl = 1'b1;
            default:                 ctrl = 1'b0;
        endcase
        return ctrl;
    endfunction

endpackage

`default_nettype wire

// File: unified_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_cfg.svh"

module unified_mem (
    input  wire logic                 i_rst,
    input  wire logic                 clk,
    input  wire logic                 i_req,
    input  wire logic                 i_we,
    input  wire lc3b_types::lc3b_addr i_addr,
    input  wire lc3b_types::lc3b_word i_wdata,
    input  wire logic                 i_load_we,
    input  wire lc3b_types::lc3b_addr i_load_addr,
    input  wire lc3b_types::lc3b_word i_load_data,
    output logic                      o_resp,
    output lc3b_types::lc3b_word      o_rdata
);
    import lc3b_types::*;

    localparam int LAT = `LC3B_MEM_LAT;

    lc3b_word       mem [`LC3B_MEM_WORDS];
    lc3b_word       data_pipe [LAT];
    logic [LAT-1:0] resp_pipe;

    always_ff @(posedge clk) begin
        if (i_load_we) begin
            mem[i_load_addr] <= i_load_data; // program load during reset.
        end else if (i_req && i_we) begin
            mem[i_addr] <= i_wdata;
        end
        data_pipe[0] <= mem[i_addr]; // read is sampled at the grant.
        for (int i = 1; i < LAT; i++) begin
            data_pipe[i] <= data_pipe[i - 1];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            resp_pipe <= '0;
        end else begin
            resp_pipe[0] <= i_req;
            for (int i = 1; i < LAT; i++) begin
                resp_pipe[i] <= resp_pipe[i - 1];
            end
        end
    end

    assign o_resp  = resp_pipe[LAT-1];
    assign o_rdata = data_pipe[LAT-1];

endmodule

`default_nettype wire

// File: mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire logic                 clk,
    input  wire logic                 i_rst,
    input  wire logic                 i_f_req,
    input  wire lc3b_types::lc3b_addr i_f_addr,
    output logic                      o_f_resp,
    output lc3b_types::lc3b_word      o_f_rdata,
    input  wire logic                 i_d_req,
    input  wire logic                 i_d_we,
    input  wire lc3b_types::lc3b_addr i_d_addr,
    input  wire lc3b_types::lc3b_word i_d_wdata,
    output logic                      o_d_resp,
    output lc3b_types::lc3b_word      o_d_rdata,
    output logic                      o_m_req,
    output logic                      o_m_we,
    output lc3b_types::lc3b_addr      o_m_addr,
    output lc3b_types::lc3b_word      o_m_wdata,
    input  wire logic                 i_m_resp,
    input  wire lc3b_types::lc3b_word i_m_rdata
);
    import lc3b_types::*;

    lc3b_arb_state state;
    logic          owner_d; // current grant belongs to the data side.
    logic          f_pend, d_pend;
    lc3b_addr      f_addr_q, d_addr_q;
    logic          d_we_q;
    lc3b_word      d_wdata_q;
    logic          f_want, d_want;
    logic          grant_f, grant_d;
    lc3b_addr      f_addr_sel, d_addr_sel;

    assign f_want     = i_f_req || f_pend;
    assign d_want     = i_d_req || d_pend;
    assign f_addr_sel = i_f_req ? i_f_addr : f_addr_q;
    assign d_addr_sel = i_d_req ? i_d_addr : d_addr_q;

    assign grant_d = (state == arb_idle) && d_want; // data side wins a tie.
    assign grant_f = (state == arb_idle) && !d_want && f_want;

    assign o_m_req   = grant_d || grant_f;
    assign o_m_we    = grant_d && (i_d_req ? i_d_we : d_we_q);
    assign o_m_addr  = grant_d ? d_addr_sel : f_addr_sel;
    assign o_m_wdata = i_d_req ? i_d_wdata : d_wdata_q;

    assign o_f_resp  = i_m_resp && (state == arb_busy) && !owner_d;
    assign o_d_resp  = i_m_resp && (state == arb_busy) && owner_d;
    assign o_f_rdata = i_m_rdata;
    assign o_d_rdata = i_m_rdata;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state   <= arb_idle;
            owner_d <= 1'b0;
            f_pend  <= 1'b0;
            d_pend  <= 1'b0;
        end else begin
            f_pend <= f_want && !grant_f;
            d_pend <= d_want && !grant_d;
            case (state)
                arb_idle: begin
                    if (o_m_req) begin
                        state   <= arb_busy;
                        owner_d <= grant_d;
                    end
                end
                arb_busy: begin
                    if (i_m_resp) begin
                        state <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_f_req) begin
            f_addr_q <= i_f_addr;
        end
        if (i_d_req) begin
            d_addr_q  <= i_d_addr;
            d_we_q    <= i_d_we;
            d_wdata_q <= i_d_wdata;
        end
    end

endmodule

`default_nettype wire

// File: fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire logic                 clk,
    input  wire logic                 i_rst,
    input  wire logic                 i_fetch_en,
    input  wire logic                 i_load_pc,
    input  wire logic                 i_redirect,
    input  wire lc3b_types::lc3b_addr i_target,
    output logic                      o_req,
    output lc3b_types::lc3b_addr      o_addr,
    input  wire logic                 i_resp,
    input  wire lc3b_types::lc3b_word i_rdata,
    output logic                      o_buf_valid,
    output lc3b_types::lc3b_word      o_buf_instr,
    output lc3b_types::lc3b_addr      o_buf_pc
);
    import lc3b_types::*;

    lc3b_addr pc;
    logic     outstanding;
    logic     stale; // the outstanding fetch was overtaken by a redirect.
    logic     buf_valid;
    lc3b_word buf_instr;
    logic     keep_resp;

    assign o_req     = i_fetch_en && !outstanding && !buf_valid;
    assign o_addr    = pc;
    assign keep_resp = i_resp && !stale && !i_redirect;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc          <= '0;
            outstanding <= 1'b0;
            stale       <= 1'b0;
            buf_valid   <= 1'b0;
        end else begin
            if (o_req) begin
                outstanding <= 1'b1;
            end else if (i_resp) begin
                outstanding <= 1'b0;
            end
            if (i_redirect) begin
                pc        <= i_target;
                buf_valid <= 1'b0;
                stale     <= outstanding && !i_resp;
            end else begin
                if (i_load_pc) begin
                    pc        <= pc + 9'd1; // buffered word moves into ID.
                    buf_valid <= 1'b0;
                end
                if (i_resp) begin
                    stale <= 1'b0;
                end
                if (keep_resp) begin
                    buf_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (keep_resp) begin
            buf_instr <= i_rdata;
        end
    end

    assign o_buf_valid = buf_valid;
    assign o_buf_instr = buf_instr;
    assign o_buf_pc    = pc; // pc only steps once the buffer is consumed.

endmodule

`default_nettype wire

// File: pipe_stages.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_stages (
    input  wire logic                   clk,
    input  wire logic                   i_rst,
    input  wire logic                   i_advance,
    input  wire logic                   i_take_fetch,
    input  wire lc3b_types::lc3b_word   i_instr,
    input  wire lc3b_types::lc3b_addr   i_pc,
    output lc3b_types::lc3b_opcode      o_op_id,
    output lc3b_types::lc3b_opcode      o_op_ex,
    output lc3b_types::lc3b_opcode      o_op_mem,
    output lc3b_types::lc3b_opcode      o_op_wb,
    output lc3b_types::lc3b_nzp         o_nzp_id,
    output lc3b_types::lc3b_nzp         o_nzp_ex,
    output lc3b_types::lc3b_nzp         o_nzp_mem,
    output lc3b_types::lc3b_nzp         o_nzp_wb,
    output lc3b_types::lc3b_addr        o_target_wb,
    output logic                        o_d_req,
    output logic                        o_d_we,
    output lc3b_types::lc3b_addr        o_d_addr,
    output lc3b_types::lc3b_word        o_d_wdata,
    input  wire logic                   i_d_resp,
    input  wire lc3b_types::lc3b_word   i_d_rdata,
    output logic                        o_mem_busy,
    output logic                        o_d_done,
    output logic                        o_wb_valid,
    output lc3b_types::lc3b_addr        o_wb_pc,
    output lc3b_types::lc3b_word        o_wb_instr,
    output lc3b_types::lc3b_word        o_wb_data
);
    import lc3b_types::*;

    localparam int S_ID  = 0;
    localparam int S_EX  = 1;
    localparam int S_MEM = 2;
    localparam int S_WB  = 3;

    lc3b_word   instr_q [4]; // a bubble is held as all zeros.
    lc3b_addr   pc_q [4];
    logic [3:0] valid_q;
    lc3b_word   mem_data_q, wb_data_q;
    logic       issue_q, done_q;
    lc3b_opcode op_ex;
    logic       flush;

    assign op_ex     = lc3b_opcode'(instr_q[S_EX][15:12]);
    assign o_op_id   = lc3b_opcode'(instr_q[S_ID][15:12]);
    assign o_op_mem  = lc3b_opcode'(instr_q[S_MEM][15:12]);
    assign o_op_wb   = lc3b_opcode'(instr_q[S_WB][15:12]);
    assign o_op_ex   = op_ex;
    assign o_nzp_id  = instr_q[S_ID][11:9];
    assign o_nzp_ex  = instr_q[S_EX][11:9];
    assign o_nzp_mem = instr_q[S_MEM][11:9];
    assign o_nzp_wb  = instr_q[S_WB][11:9];
    assign flush     = is_control(o_op_wb, o_nzp_wb);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int s = 0; s < 4; s++) begin
                instr_q[s] <= '0;
            end
            valid_q <= '0;
            issue_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            issue_q <= 1'b0;
            if (i_d_resp) begin
                done_q <= 1'b1;
            end
            if (i_advance) begin
                done_q          <= 1'b0;
                instr_q[S_WB]   <= instr_q[S_MEM];
                valid_q[S_WB]   <= valid_q[S_MEM];
                if (flush) begin
                    instr_q[S_MEM] <= '0;
                    instr_q[S_EX]  <= '0;
                    instr_q[S_ID]  <= '0;
                    valid_q[2:0]   <= 3'b000;
                end else begin
                    instr_q[S_MEM] <= instr_q[S_EX];
                    instr_q[S_EX]  <= instr_q[S_ID];
                    instr_q[S_ID]  <= i_take_fetch ? i_instr : '0;
                    valid_q[2:0]   <= {valid_q[S_EX], valid_q[S_ID], i_take_fetch};
                    issue_q        <= (op_ex == op_ldw) || (op_ex == op_stw);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_d_resp) begin
            mem_data_q <= i_d_rdata;
        end
        if (i_advance) begin
            pc_q[S_ID]  <= i_pc;
            pc_q[S_EX]  <= pc_q[S_ID];
            pc_q[S_MEM] <= pc_q[S_EX];
            pc_q[S_WB]  <= pc_q[S_MEM];
            wb_data_q   <= (o_op_mem == op_ldw) ? mem_data_q : '0;
        end
    end

    assign o_d_req     = issue_q;
    assign o_d_we      = (o_op_mem == op_stw);
    assign o_d_addr    = instr_q[S_MEM][8:0];
    assign o_d_wdata   = lc3b_word'(pc_q[S_MEM]); // a store writes its own pc.
    assign o_mem_busy  = (o_op_mem == op_ldw) || (o_op_mem == op_stw);
    assign o_d_done    = done_q;
    assign o_target_wb = instr_q[S_WB][8:0];
    assign o_wb_valid  = valid_q[S_WB] && i_advance;
    assign o_wb_pc     = pc_q[S_WB];
    assign o_wb_instr  = instr_q[S_WB];
    assign o_wb_data   = wb_data_q;

endmodule

`default_nettype wire

// File: hazard_detection.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_detection (
    input  wire logic                   i_fetch_ready,
    input  wire logic                   i_d_busy,
    input  wire logic                   i_d_done,
    input  wire lc3b_types::lc3b_opcode i_op_id,
    input  wire lc3b_types::lc3b_opcode i_op_ex,
    input  wire lc3b_types::lc3b_opcode i_op_mem,
    input  wire lc3b_types::lc3b_opcode i_op_wb,
    input  wire lc3b_types::lc3b_nzp    i_nzp_id,
    input  wire lc3b_types::lc3b_nzp    i_nzp_ex,
    input  wire lc3b_types::lc3b_nzp    i_nzp_mem,
    input  wire lc3b_types::lc3b_nzp    i_nzp_wb,
    output logic                        o_load,
    output logic                        o_load_pc,
    output logic                        o_control_wb,
    output logic                        o_fetch_en
);
    import lc3b_types::*;

    logic ctrl_id, ctrl_ex, ctrl_mem, ctrl_wb;
    logic data_ok;

    assign ctrl_id  = is_control(i_op_id, i_nzp_id);
    assign ctrl_ex  = is_control(i_op_ex, i_nzp_ex);
    assign ctrl_mem = is_control(i_op_mem, i_nzp_mem);
    assign ctrl_wb  = is_control(i_op_wb, i_nzp_wb);

    assign data_ok = !i_d_busy || i_d_done; // MEM has no access or it has finished.

    // any transfer in flight means the fetched words would be on the wrong path.
    always_comb begin
        o_fetch_en   = !(ctrl_id || ctrl_ex || ctrl_mem || ctrl_wb);
        o_control_wb = ctrl_wb;
    end

    always_comb begin
        o_load    = data_ok && (i_fetch_ready || !o_fetch_en);
        o_load_pc = o_load && i_fetch_ready;
        if (o_control_wb) begin
            o_load_pc = 1'b1; // redirect from WB.
        end
    end

endmodule

`default_nettype wire

// File: lc3b_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module lc3b_pipe_top (
    input  wire logic                 clk,
    input  wire logic                 i_rst,
    input  wire logic                 i_load_we,
    input  wire lc3b_types::lc3b_addr i_load_addr,
    input  wire lc3b_types::lc3b_word i_load_data,
    output logic                      o_wb_valid,
    output lc3b_types::lc3b_addr      o_wb_pc,
    output lc3b_types::lc3b_word      o_wb_instr,
    output lc3b_types::lc3b_word      o_wb_data,
    output logic                      o_redirect,
    output lc3b_types::lc3b_addr      o_redirect_target
);
    import lc3b_types::*;

    logic       m_req, m_we, m_resp;
    lc3b_addr   m_addr;
    lc3b_word   m_wdata, m_rdata;
    logic       f_req, f_resp;
    lc3b_addr   f_addr;
    lc3b_word   f_rdata;
    logic       d_req, d_we, d_resp;
    lc3b_addr   d_addr;
    lc3b_word   d_wdata, d_rdata;
    logic       buf_valid;
    lc3b_word   buf_instr;
    lc3b_addr   buf_pc;
    logic       load, load_pc, control_wb, fetch_en;
    logic       mem_busy, d_done;
    lc3b_opcode op_id, op_ex, op_mem, op_wb;
    lc3b_nzp    nzp_id, nzp_ex, nzp_mem, nzp_wb;
    lc3b_addr   target_wb;

    unified_mem u_mem (
        .i_rst(i_rst), .clk(clk), .i_req(m_req), .i_we(m_we), .i_addr(m_addr),
        .i_wdata(m_wdata), .i_load_we(i_load_we), .i_load_addr(i_load_addr),
        .i_load_data(i_load_data), .o_resp(m_resp), .o_rdata(m_rdata)
    );

    mem_arbiter u_arb (
        .clk(clk), .i_rst(i_rst),
        .i_f_req(f_req), .i_f_addr(f_addr), .o_f_resp(f_resp), .o_f_rdata(f_rdata),
        .i_d_req(d_req), .i_d_we(d_we), .i_d_addr(d_addr), .i_d_wdata(d_wdata),
        .o_d_resp(d_resp), .o_d_rdata(d_rdata),
        .o_m_req(m_req), .o_m_we(m_we), .o_m_addr(m_addr), .o_m_wdata(m_wdata),
        .i_m_resp(m_resp), .i_m_rdata(m_rdata)
    );

    fetch_unit u_fetch (
        .clk(clk), .i_rst(i_rst), .i_fetch_en(fetch_en), .i_load_pc(load_pc),
        .i_redirect(control_wb), .i_target(target_wb), .o_req(f_req), .o_addr(f_addr),
        .i_resp(f_resp), .i_rdata(f_rdata), .o_buf_valid(buf_valid),
        .o_buf_instr(buf_instr), .o_buf_pc(buf_pc)
    );

    pipe_stages u_stages (
        .clk(clk), .i_rst(i_rst), .i_advance(load), .i_take_fetch(fetch_en),
        .i_instr(buf_instr), .i_pc(buf_pc),
        .o_op_id(op_id), .o_op_ex(op_ex), .o_op_mem(op_mem), .o_op_wb(op_wb),
        .o_nzp_id(nzp_id), .o_nzp_ex(nzp_ex), .o_nzp_mem(nzp_mem), .o_nzp_wb(nzp_wb),
        .o_target_wb(target_wb), .o_d_req(d_req), .o_d_we(d_we), .o_d_addr(d_addr),
        .o_d_wdata(d_wdata), .i_d_resp(d_resp), .i_d_rdata(d_rdata),
        .o_mem_busy(mem_busy), .o_d_done(d_done), .o_wb_valid(o_wb_valid),
        .o_wb_pc(o_wb_pc), .o_wb_instr(o_wb_instr), .o_wb_data(o_wb_data)
    );

    hazard_detection u_hazard (
        .i_fetch_ready(buf_valid), .i_d_busy(mem_busy), .i_d_done(d_done),
        .i_op_id(op_id), .i_op_ex(op_ex), .i_op_mem(op_mem), .i_op_wb(op_wb),
        .i_nzp_id(nzp_id), .i_nzp_ex(nzp_ex), .i_nzp_mem(nzp_mem), .i_nzp_wb(nzp_wb),
        .o_load(load), .o_load_pc(load_pc), .o_control_wb(control_wb),
        .o_fetch_en(fetch_en)
    );

    assign o_redirect        = control_wb;
    assign o_redirect_target = target_wb;

endmodule

`default_nettype wire

// File: lc3b_pipe_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_cfg.svh"

module lc3b_pipe_props (
    input wire logic clk,
    input wire logic i_rst,
    input wire logic i_m_req,
    input wire logic i_m_resp,
    input wire logic i_fetch_en,
    input wire logic i_buf_valid,
    input wire logic i_control_wb
);
    localparam int LAT = `LC3B_MEM_LAT;

    logic [LAT-1:0] grant_hist; // bit k is the grant strobe of k+1 cycles ago.

    always_ff @(posedge clk) begin
        if (i_rst) begin
            grant_hist <= '0;
        end else begin
            grant_hist <= {grant_hist[LAT-2:0], i_m_req};
        end
    end

    single_grant: assert property (@(posedge clk) disable iff (i_rst)
        i_m_req |-> (grant_hist == '0))
        else $error("memory granted while an earlier grant was still in flight");

    resp_latency: assert property (@(posedge clk) disable iff (i_rst)
        i_m_resp == grant_hist[LAT-1])
        else $error("memory response did not come exactly LAT cycles after its grant");

    // no word may have been fetched on the wrong path behind the transfer.
    fetch_blocked: assert property (@(posedge clk) disable iff (i_rst)
        i_control_wb |-> !i_fetch_en && !i_buf_valid)
        else $error("fetch active while WB holds a control transfer");

endmodule

// the arbiter's memory side, the fetch buffer and the hazard_detection outputs meet in the top level.
bind lc3b_pipe_top lc3b_pipe_props props0 (
    .clk(clk), .i_rst(i_rst), .i_m_req(m_req), .i_m_resp(m_resp),
    .i_fetch_en(fetch_en), .i_buf_valid(buf_valid), .i_control_wb(control_wb)
);

`default_nettype wire

// File: tb_lc3b_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc3b_cfg.svh"

module tb_lc3b_pipe;
    import lc3b_types::*;

    localparam int PROG_WORDS = 128;   // code sits below the data window at 256.
    localparam int N_RETIRE   = 300;
    localparam int RUN_LIMIT  = 20000;

    logic     clk;
    logic     i_rst;
    logic     i_load_we;
    lc3b_addr i_load_addr;
    lc3b_word i_load_data;
    logic     o_wb_valid;
    lc3b_addr o_wb_pc;
    lc3b_word o_wb_instr;
    lc3b_word o_wb_data;
    logic     o_redirect;
    lc3b_addr o_redirect_target;

    integer   seed;
    lc3b_word image [`LC3B_MEM_WORDS];
    lc3b_word model_mem [`LC3B_MEM_WORDS];
    lc3b_addr model_pc;
    int       retired;
    int       errors;
    logic     checking;

    lc3b_pipe_top dut0 (
        .clk(clk), .i_rst(i_rst), .i_load_we(i_load_we), .i_load_addr(i_load_addr),
        .i_load_data(i_load_data), .o_wb_valid(o_wb_valid), .o_wb_pc(o_wb_pc),
        .o_wb_instr(o_wb_instr), .o_wb_data(o_wb_data), .o_redirect(o_redirect),
        .o_redirect_target(o_redirect_target)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic compare(input string name, input lc3b_word actual, input lc3b_word expected);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED: %s got %h expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    function automatic logic transfers_control(input lc3b_word instr);
        lc3b_opcode op;
        op = lc3b_opcode'(instr[15:12]);
        if (op == op_br) begin
            return instr[11:9] != 3'b000;
        end
        return (op == op_jmp) || (op == op_jsr) || (op == op_trap);
    endfunction

    function automatic lc3b_opcode noop_opcode(input logic [3:0] sel);
        case (sel)
            4'd0:    return op_add;
            4'd1:    return op_ldb;
            4'd2:    return op_stb;
            4'd3:    return op_and;
            4'd4:    return op_rti;
            4'd5:    return op_not;
            4'd6:    return op_ldi;
            4'd7:    return op_sti;
            4'd8:    return op_shf;
            default: return op_lea;
        endcase
    endfunction

    task automatic build_image();
        logic [31:0] r;
        lc3b_addr    target;
        lc3b_addr    daddr;
        for (int a = 0; a < `LC3B_MEM_WORDS; a++) begin
            image[a] = {a[3:0], 3'b101, a[8:0]}; // every address bit shows in the word.
        end
        for (int a = 0; a < PROG_WORDS - 1; a++) begin
            r      = $random(seed);
            target = {2'b00, r[10:4]};
            daddr  = {4'b1000, r[15:11]}; // small data window so loads hit stored words.
            case (r[3:0])
                4'd0:         image[a] = {op_br, r[18:16], target};
                4'd1:         image[a] = {op_br, 3'b000, target}; // never taken.
                4'd2:         image[a] = {op_jmp, r[18:16], target};
                4'd3:         image[a] = {r[23] ? op_jsr : op_trap, r[18:16], target};
                4'd4, 4'd5,
                4'd6:         image[a] = {op_ldw, r[18:16], daddr};
                4'd7, 4'd8:   image[a] = {op_stw, r[18:16], daddr};
                default:      image[a] = {noop_opcode(r[22:19]), r[31:20]};
            endcase
        end
        image[PROG_WORDS - 1] = {op_jmp, 3'b000, 9'd0}; // keeps fetch inside the code.
        model_mem = image;
    endtask

    task automatic check_retire();
        lc3b_word   exp_instr;
        lc3b_opcode op;
        lc3b_addr   next_pc;
        logic       taken;
        exp_instr = model_mem[model_pc];
        op        = lc3b_opcode'(exp_instr[15:12]);
        taken     = transfers_control(exp_instr);
        next_pc   = model_pc + 9'd1;
        compare("o_wb_pc", {7'b0, o_wb_pc}, {7'b0, model_pc});
        compare("o_wb_instr", o_wb_instr, exp_instr);
        compare("o_redirect", {15'b0, o_redirect}, {15'b0, taken});
        if (taken) begin
            compare("o_redirect_target", {7'b0, o_redirect_target}, {7'b0, exp_instr[8:0]});
            next_pc = exp_instr[8:0];
        end
        if (op == op_ldw) begin
            compare("o_wb_data", o_wb_data, model_mem[exp_instr[8:0]]);
        end
        if (op == op_stw) begin
            model_mem[exp_instr[8:0]] = {7'b0, model_pc};
        end
        model_pc = next_pc;
        retired++;
    endtask

    always @(negedge clk) begin
        if (checking) begin
            if (o_wb_valid) begin
                check_retire();
            end else begin
                compare("o_redirect", {15'b0, o_redirect}, 16'h0000);
            end
        end
    end

    initial begin
        int waited;
        i_rst       <= 1'b1;
        i_load_we   <= 1'b0;
        i_load_addr <= '0;
        i_load_data <= '0;
        seed        = 51;
        retired     = 0;
        errors      = 0;
        checking    = 1'b0;
        model_pc    = '0;
        build_image();
        for (int a = 0; a < `LC3B_MEM_WORDS; a++) begin
            @(posedge clk);
            i_load_we   <= 1'b1;
            i_load_addr <= lc3b_addr'(a);
            i_load_data <= image[a];
        end
        @(posedge clk);
        i_load_we <= 1'b0;
        repeat (5) @(posedge clk); // five plain reset cycles once the image is in.
        i_rst    <= 1'b0;
        checking <= 1'b1;
        waited = 0;
        while (retired < N_RETIRE && waited < RUN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        checking = 1'b0;
        if (retired < N_RETIRE) begin
            $display("timeout: only %0d of %0d instructions retired in %0d cycles",
                     retired, N_RETIRE, waited);
            errors++;
        end
        $display("retired %0d instructions, %0d errors", retired, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ps \
    -f sources.f --top-module tb_lc3b_pipe -o tb_lc3b_pipe

./obj_dir/tb_lc3b_pipe > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"

// File: sources.f
+incdir+.
lc3b_types.sv
unified_mem.sv
mem_arbiter.sv
fetch_unit.sv
pipe_stages.sv
hazard_detection.sv
lc3b_pipe_top.sv
lc3b_pipe_props.sv
tb_lc3b_pipe.sv
